// File: common/pokey_regs_pkg.sv
package pokey_regs_pkg;

    // cpu side of the register port
    localparam int cpu_addr_w = 4;
    localparam int cpu_data_w = 8;

    typedef logic [cpu_addr_w-1:0] cpu_addr_t;
    typedef logic [cpu_data_w-1:0] cpu_data_t;

    // read map
    localparam cpu_addr_t addr_pot0   = 4'd0;
    localparam cpu_addr_t addr_pot1   = 4'd1;
    localparam cpu_addr_t addr_pot2   = 4'd2;
    localparam cpu_addr_t addr_pot3   = 4'd3;
    localparam cpu_addr_t addr_pot4   = 4'd4;
    localparam cpu_addr_t addr_pot5   = 4'd5;
    localparam cpu_addr_t addr_pot6   = 4'd6;
    localparam cpu_addr_t addr_pot7   = 4'd7;
    localparam cpu_addr_t addr_allpot = 4'd8;
    localparam cpu_addr_t addr_kbcode = 4'd9;
    localparam cpu_addr_t addr_skstat = 4'd15;  // bit 2 low while a key is held

    // write map, only potgo is modelled
    localparam cpu_addr_t addr_potgo  = 4'd11;

    // undecoded reads float high on the bus
    localparam cpu_data_t rd_unmapped = 8'hff;

endpackage

// File: common/pokey_scan_pkg.sv
package pokey_scan_pkg;

    // keyboard scan
    localparam int key_code_w = 4;

    typedef logic [key_code_w-1:0] key_code_t;  // one of 16 keys on kr1

    // paddle conversion
    localparam int pot_count_w = 8;
    localparam int num_pots    = 8;

    typedef logic [pot_count_w-1:0] pot_count_t;  // tv line count

    // last line of a conversion, pots still open read this
    localparam pot_count_t pot_max_line = 8'd228;

    // all eight pot results side by side, pot i at index i
    typedef pot_count_t [num_pots-1:0] pot_bus_t;

    // line count that leaves a pot converting at the end
    // is forced to pot_max_line, so no value above it exists

endpackage

// File: common/pot_ctrl_if.sv
`timescale 1ns/1ps

// potgo request one way, pot results the other
interface pot_ctrl_if;
    import pokey_scan_pkg::*;

    logic                potgo;     // one cycle strobe from the register block
    pot_bus_t            pot_vals;  // captured line counts
    logic [num_pots-1:0] allpot;    // 1 = pot still converting
    logic                dump;      // capacitor dump, also a chip pin

    modport regs (
        output potgo,
        input  pot_vals,
        input  allpot
    );

    modport scan (
        input  potgo,
        output pot_vals,
        output allpot,
        output dump
    );

endinterface

// File: src/key_scanner.sv
`timescale 1ns/1ps

module key_scanner (
    input  logic                      o2,
    input  logic                      reset,
    input  logic                      kr1,       // low while scanned key is down
    output pokey_scan_pkg::key_code_t key_scan,  // scan index, active low
    output pokey_scan_pkg::key_code_t kbcode,
    output logic                      key_depr
);
    import pokey_scan_pkg::*;

    key_code_t scan_ctr;       // walks keys 0..15, one per clock
    key_code_t compare_latch;  // first pressed index seen
    logic      armed;          // compare latch holds a candidate
    logic      hit;            // scan is back at the candidate

    assign key_scan = ~scan_ctr;  // pins are inverted
    assign hit      = (scan_ctr == compare_latch);

    // free running scan, 4 bits so 15 wraps to 0
    always_ff @(posedge o2) begin
        if (reset) begin
            scan_ctr <= '0;
        end else begin
            scan_ctr <= scan_ctr + 1'b1;
        end
    end

    // two pass debounce
    // pass 1 arms the compare latch, pass 2 at the same index accepts it
    always_ff @(posedge o2) begin
        if (reset) begin
            compare_latch <= '0;
            armed         <= 1'b0;
            kbcode        <= '0;
            key_depr      <= 1'b0;
        end else if (!armed) begin
            if (!kr1) begin
                compare_latch <= scan_ctr;  // remember first key down
                armed         <= 1'b1;
            end
        end else if (hit) begin
            if (!kr1) begin
                // same key still down a full pass later
                kbcode   <= compare_latch;
                key_depr <= 1'b1;
            end else begin
                // candidate came round with kr1 high, treat as release
                armed    <= 1'b0;
                kbcode   <= '0;
                key_depr <= 1'b0;
            end
        end
        // other keys while armed are ignored
    end

    // kbcode settles 16 clocks after arming
    // so 16..32 clocks after kr1 first drops for the key,
    // depending on where the scan was when it went down
    // a bouncing key that misses pass 2 just releases the latch

endmodule

// File: pot/pot_scanner.sv
`timescale 1ns/1ps

module pot_scanner (
    input  logic                                o2,
    input  logic                                reset,
    input  logic                                line_tick,  // one pulse per tv line
    input  logic [pokey_scan_pkg::num_pots-1:0] pot_scan,   // cap above threshold
    pot_ctrl_if.scan                            ctrl
);
    import pokey_scan_pkg::*;

    pot_count_t          line_cnt;    // 0..228
    logic                converting;  // counting lines
    logic [num_pots-1:0] latched;     // pot already has its value
    logic                at_max;      // last line of the conversion
    logic                step;        // line boundary while converting
    logic [num_pots-1:0] capture;     // pot takes line_cnt this cycle

    assign at_max = (line_cnt == pot_max_line);
    assign step   = converting && line_tick;

    // capture on a line edge once the cap crosses threshold
    // at the last line every open pot is forced to 228
    always_comb begin
        for (int i = 0; i < num_pots; i++) begin
            capture[i] = step && !latched[i] && (pot_scan[i] || at_max);
        end
    end

    // pot_scan is taken as already synchronous to o2

    always_ff @(posedge o2) begin
        if (reset) begin
            line_cnt    <= '0;
            converting  <= 1'b0;
            latched     <= '0;
            ctrl.allpot <= '0;
            ctrl.dump   <= 1'b0;
        end else if (ctrl.potgo) begin
            // restart, discharge caps until next line
            line_cnt    <= '0;
            converting  <= 1'b0;
            latched     <= '0;
            ctrl.allpot <= '1;
            ctrl.dump   <= 1'b1;
        end else if (ctrl.dump) begin
            if (line_tick) begin
                ctrl.dump  <= 1'b0;  // release caps, count from here
                converting <= 1'b1;
            end
        end else if (step) begin
            latched     <= latched | capture;
            ctrl.allpot <= ctrl.allpot & ~capture;
            if (at_max) begin
                converting <= 1'b0;  // all pots closed, hold until potgo
            end else begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

    // captured values, cleared by potgo only
    always_ff @(posedge o2) begin
        for (int i = 0; i < num_pots; i++) begin
            if (ctrl.potgo) begin
                ctrl.pot_vals[i] <= '0;
            end else if (capture[i]) begin
                ctrl.pot_vals[i] <= line_cnt;
            end
        end
    end

    // allpot hits zero on the last line at the latest
    // so the cpu polls it to see the end of a conversion

endmodule

// File: src/io_regs.sv
`timescale 1ns/1ps

module io_regs (
    input  logic                      o2,
    input  logic                      reset,
    input  logic                      cs,
    input  logic                      rw,        // 1 = read
    input  pokey_regs_pkg::cpu_addr_t addr,
    input  pokey_regs_pkg::cpu_data_t data_in,   // don't care for potgo, as on the chip
    output pokey_regs_pkg::cpu_data_t data_out,
    input  pokey_scan_pkg::key_code_t kbcode,
    input  logic                      key_depr,
    pot_ctrl_if.regs                  ctrl
);
    import pokey_regs_pkg::*;

    logic      cpu_rd;
    logic      cpu_wr;
    cpu_data_t rd_mux;

    assign cpu_rd = cs && rw;
    assign cpu_wr = cs && !rw;

    // read select
    always_comb begin
        case (addr)
            addr_pot0:   rd_mux = ctrl.pot_vals[0];
            addr_pot1:   rd_mux = ctrl.pot_vals[1];
            addr_pot2:   rd_mux = ctrl.pot_vals[2];
            addr_pot3:   rd_mux = ctrl.pot_vals[3];
            addr_pot4:   rd_mux = ctrl.pot_vals[4];
            addr_pot5:   rd_mux = ctrl.pot_vals[5];
            addr_pot6:   rd_mux = ctrl.pot_vals[6];
            addr_pot7:   rd_mux = ctrl.pot_vals[7];
            addr_allpot: rd_mux = ctrl.allpot;
            addr_kbcode: rd_mux = {4'h0, kbcode};
            addr_skstat: rd_mux = {5'b11111, ~key_depr, 2'b11};  // bit 2 active low
            default:     rd_mux = rd_unmapped;
        endcase
    end

    always_ff @(posedge o2) begin
        if (reset) begin
            ctrl.potgo <= 1'b0;
            data_out   <= '0;
        end else begin
            // strobe lands the cycle after the write edge
            ctrl.potgo <= cpu_wr && (addr == addr_potgo);
            if (cpu_rd) begin
                data_out <= rd_mux;  // one cycle read latency, held between reads
            end
        end
    end

endmodule

// File: src/pokey_io_top.sv
`timescale 1ns/1ps

module pokey_io_top (
    input  logic                                o2,
    input  logic                                reset,
    input  logic                                line_tick,
    input  logic [pokey_scan_pkg::num_pots-1:0] pot_scan,
    input  logic                                kr1,
    output pokey_scan_pkg::key_code_t           key_scan,
    input  logic                                cs,
    input  logic                                rw,
    input  pokey_regs_pkg::cpu_addr_t           addr,
    input  pokey_regs_pkg::cpu_data_t           data_in,
    output pokey_regs_pkg::cpu_data_t           data_out,
    output logic                                pot_dump
);

    pokey_scan_pkg::key_code_t kbcode;
    logic                      key_depr;

    pot_ctrl_if ctrl ();  // register block <-> pot scanner

    assign pot_dump = ctrl.dump;

    key_scanner i_key_scanner (
        .o2       (o2),
        .reset    (reset),
        .kr1      (kr1),
        .key_scan (key_scan),
        .kbcode   (kbcode),
        .key_depr (key_depr)
    );

    pot_scanner i_pot_scanner (
        .o2        (o2),
        .reset     (reset),
        .line_tick (line_tick),
        .pot_scan  (pot_scan),
        .ctrl      (ctrl.scan)
    );

    io_regs i_io_regs (
        .o2       (o2),
        .reset    (reset),
        .cs       (cs),
        .rw       (rw),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .kbcode   (kbcode),
        .key_depr (key_depr),
        .ctrl     (ctrl.regs)
    );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o2,
    output logic reset
);
    localparam int reset_cycles = 5;

    // 20 ns o2
    initial begin
        o2 = 1'b0;
        forever #10 o2 = ~o2;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge o2);
        @(negedge o2);
        reset = 1'b0;  // let go on a falling edge like every other input
    end

endmodule

// File: dv/pokey_io_asserts.sv
`timescale 1ns/1ps

module pokey_io_asserts (
    input logic                                o2,
    input logic                                reset,
    input logic                                line_tick,
    input logic                                potgo,
    input logic                                dump,
    input pokey_scan_pkg::pot_count_t          line_cnt,
    input logic [pokey_scan_pkg::num_pots-1:0] latched,
    input pokey_scan_pkg::pot_bus_t            pot_vals
);
    import pokey_scan_pkg::*;

    // caps are released only at a line boundary
    dump_falls_on_tick: assert property (@(posedge o2) disable iff (reset)
        $fell(dump) |-> $past(line_tick))
        else $error("dump fell without a line_tick before it");

    line_cnt_in_range: assert property (@(posedge o2) disable iff (reset)
        line_cnt <= pot_max_line)
        else $error("line count ran past the last line");

    // a captured value sticks until the next potgo
    for (genvar i = 0; i < num_pots; i++) begin : g_pot_hold
        pot_value_held: assert property (@(posedge o2) disable iff (reset)
            latched[i] && !potgo |=> $stable(pot_vals[i]))
            else $error("pot %0d changed after it was latched", i);
    end

endmodule

// File: dv/pokey_io_tb.sv
`timescale 1ns/1ps

module pokey_io_tb;
    import pokey_regs_pkg::*;
    import pokey_scan_pkg::*;

    localparam int tick_period = 4;  // o2 cycles per tv line
    localparam int test_cycles = 230 * tick_period + 100;

    logic                o2;
    logic                reset;
    logic                line_tick = 1'b0;
    logic [num_pots-1:0] pot_scan = '0;
    logic                kr1 = 1'b1;
    key_code_t           key_scan;
    logic                cs;
    logic                rw;
    cpu_addr_t           addr;
    cpu_data_t           data_in;
    cpu_data_t           data_out;
    logic                pot_dump;

    bit   is_pot_q[$];       // one entry per vector line
    int   arg_q[$];          // eight args per vector line
    int   thr[num_pots];     // paddle thresholds in lines
    int   held_key = 16;     // 16 = nothing down
    int   tick_div = 0;
    int   lines = 0;         // line ticks since dump fell
    bit   counting = 1'b0;
    logic prev_dump = 1'b0;
    logic tick_seen = 1'b0;  // line_tick at the last rising edge
    int   cycle_cnt = 0;
    int   cycle_limit = 0;

    tb_clock_gen i_tb_clock_gen (.o2(o2), .reset(reset));

    pokey_io_top i_pokey_io_top (
        .o2(o2), .reset(reset), .line_tick(line_tick), .pot_scan(pot_scan),
        .kr1(kr1), .key_scan(key_scan), .cs(cs), .rw(rw), .addr(addr),
        .data_in(data_in), .data_out(data_out), .pot_dump(pot_dump)
    );

    bind pot_scanner pokey_io_asserts i_pokey_io_asserts (
        .o2(o2), .reset(reset), .line_tick(line_tick), .potgo(ctrl.potgo),
        .dump(ctrl.dump), .line_cnt(line_cnt), .latched(latched),
        .pot_vals(ctrl.pot_vals)
    );

    // line timer, paddle caps and keyboard matrix on the falling edge
    always @(negedge o2) begin
        if (pot_dump) begin
            counting = 1'b0;  // caps held discharged
            lines    = 0;
        end else if (prev_dump) begin
            counting = 1'b1;  // dump dropped on the last tick so that tick counts
            lines    = 1;
        end else if (counting && line_tick) begin
            lines = lines + 1;
        end
        prev_dump = pot_dump;
        for (int i = 0; i < num_pots; i++) begin
            pot_scan[i] = counting && (lines > thr[i]);
        end
        kr1       = !((held_key < 16) && (~key_scan == key_code_t'(held_key)));
        tick_div  = (tick_div + 1) % tick_period;
        line_tick = (tick_div == 0);
    end

    always @(posedge o2) begin
        tick_seen <= line_tick;
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            stop_with_error("timeout, the tests ran past their cycle limit");
        end
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_pot(input pot_count_t got, input pot_count_t exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0d ns: %s read %0d, expected %0d",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_byte(input cpu_data_t got, input cpu_data_t exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0d ns: %s read 0x%02h, expected 0x%02h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_key(input key_code_t got, input key_code_t exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0d ns: %s read %0d, expected %0d",
                                      $time, what, got, exp));
        end
    endtask

    task automatic cpu_read(input cpu_addr_t a, output cpu_data_t d);
        @(negedge o2);
        cs   = 1'b1;
        rw   = 1'b1;
        addr = a;
        @(negedge o2);
        cs = 1'b0;
        d  = data_out;  // registered on the edge in between
    endtask

    task automatic cpu_write(input cpu_addr_t a);
        @(negedge o2);
        cs      = 1'b1;
        rw      = 1'b0;
        addr    = a;
        data_in = 8'h00;  // potgo ignores data
        @(negedge o2);
        cs = 1'b0;
        rw = 1'b1;
    endtask

    initial begin
        int        fd;
        string     line;
        int        v[num_pots];
        int        waited;
        cpu_data_t d;

        cs      = 1'b0;
        rw      = 1'b1;
        addr    = '0;
        data_in = '0;

        fd = $fopen("dv/pokey_io_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_error("could not open dv/pokey_io_vectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            if ($sscanf(line, "P %d %d %d %d %d %d %d %d",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]) == 8) begin
                is_pot_q.push_back(1'b1);
                for (int i = 0; i < num_pots; i++) begin
                    arg_q.push_back(v[i]);
                end
            end else if ($sscanf(line, "K %d", v[0]) == 1) begin
                is_pot_q.push_back(1'b0);
                for (int i = 0; i < num_pots; i++) begin
                    arg_q.push_back(v[0]);
                end
            end
        end
        $fclose(fd);
        cycle_limit = is_pot_q.size() * test_cycles;

        wait (reset === 1'b0);
        check_key(~key_scan, 4'h0, "scan index after reset");  // last edge was still in reset
        @(negedge o2);
        check_byte(data_out, 8'h00, "data_out after reset");
        check_byte(cpu_data_t'(pot_dump), 8'h00, "pot_dump after reset");
        cpu_read(addr_allpot, d);
        check_byte(d, 8'h00, "ALLPOT after reset");
        cpu_read(addr_kbcode, d);
        check_key(d[3:0], 4'h0, "KBCODE after reset");

        for (int a = 10; a <= 14; a++) begin
            cpu_read(cpu_addr_t'(a), d);
            check_byte(d, 8'hff, $sformatf("unmapped address %0d", a));
        end

        for (int t = 0; t < is_pot_q.size(); t++) begin
            if (is_pot_q[t]) begin
                for (int i = 0; i < num_pots; i++) begin
                    thr[i] = arg_q[t * num_pots + i];
                end
                cpu_write(addr_potgo);
                @(negedge o2);  // strobe seen and dump now up
                check_byte(cpu_data_t'(pot_dump), 8'h01, "pot_dump after POTGO");
                waited = 0;
                while (pot_dump) begin
                    @(negedge o2);
                    waited++;
                    if (waited > tick_period + 1) begin
                        stop_with_error("pot_dump stayed high past the next line_tick");
                    end
                end
                if (!tick_seen) begin
                    stop_with_error("pot_dump fell without a line_tick");
                end
                cpu_read(addr_allpot, d);
                check_byte(d, 8'hff, "ALLPOT while converting");
                d = 8'hff;
                while (d != 8'h00) begin
                    cpu_read(addr_allpot, d);  // end of conversion
                end
                for (int i = 0; i < num_pots; i++) begin
                    cpu_read(cpu_addr_t'(int'(addr_pot0) + i), d);
                    check_pot(d, (thr[i] < int'(pot_max_line)) ? pot_count_t'(thr[i])
                              : pot_max_line, $sformatf("POT%0d", i));
                end
            end else begin
                held_key = arg_q[t * num_pots];
                repeat (64) @(negedge o2);  // well past two scan passes
                cpu_read(addr_kbcode, d);
                check_key(d[3:0], (held_key < 16) ? key_code_t'(held_key) : 4'h0, "KBCODE");
                check_byte(d & 8'hf0, 8'h00, "KBCODE upper nibble");
                cpu_read(addr_skstat, d);
                check_byte(d, (held_key < 16) ? 8'hfb : 8'hff, "SKSTAT");
            end
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: dv/pokey_io_vectors.txt
# P t0 t1 t2 t3 t4 t5 t6 t7 : POTGO, pot i crosses after t_i lines, reads min(t_i, 228)
# K n : hold key n (0 to 15) for 64 cycles, n = 16 releases every key
P 10 20 30 40 50 60 70 80
K 5
K 16
P 0 1 2 100 150 227 228 250
K 0
K 15
K 9
K 16
P 200 3 255 17 229 64 128 90
K 12
K 16

// File: filelist.f
common/pokey_regs_pkg.sv
common/pokey_scan_pkg.sv
common/pot_ctrl_if.sv
src/key_scanner.sv
pot/pot_scanner.sv
src/io_regs.sv
src/pokey_io_top.sv
dv/tb_clock_gen.sv
dv/pokey_io_asserts.sv
dv/pokey_io_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run from the project root, nonzero exit on failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module pokey_io_tb -f filelist.f -o pokey_io_sim \
    && ./obj_dir/pokey_io_sim \
    || exit 1
